//--- pathOram_params.svh
// Build-time sizes for the path ORAM address front end.
// BKT_BURSTS must be a power of two of at least 2, and HDR_BURSTS is at most BKT_BURSTS.
// Buckets sit in plain heap order, so DDR_AW must hold the bucket index plus the burst bits.

`ifndef PATHORAM_PARAMS_SVH
`define PATHORAM_PARAMS_SVH

// leaf label width, the tree has ORAM_L+1 levels
`define ORAM_L 4

// DRAM bursts per whole bucket
`define BKT_BURSTS 4

// bursts per header-only access
`define HDR_BURSTS 1

// log2 of bytes per DRAM burst
`define BST_BYTES_LOG 6

// DRAM byte address width
`define DDR_AW 32

// command FIFO entries between generator and issue stage
`define CMD_FIFO_DEPTH 4

`endif

//--- dramCmdPkg.sv
// DRAM command types that the generator, FIFO and issue stage share.
// The field view assumes BKT_BURSTS >= 2, so the burst field is never zero width.

`default_nettype none

`include "pathOram_params.svh"

package dramCmdPkg;

	// ==============================
	// address field widths
	// ==============================
	localparam int burstW = $clog2(`BKT_BURSTS);
	localparam int offsetW = `BST_BYTES_LOG;
	localparam int bucketW = `DDR_AW - burstW - offsetW;

	// read is 1 as on the DRAM side
	typedef enum logic {
		cmdWrite = 1'b0,
		cmdRead = 1'b1
	} dramCmdE;

	// one address word, seen as a byte address or as bucket/burst/offset
	typedef union packed {
		logic [`DDR_AW-1:0] raw;
		struct packed {
			logic [bucketW-1:0] bucket;
			logic [burstW-1:0] burst;
			logic [offsetW-1:0] offset;
		} fields;
	} dramAddrU;

endpackage

`default_nettype wire

//--- hostRegPkg.sv
// Host register map and word layouts for the APB side.
// Offsets are byte offsets on an 8-bit PADDR and every register is 32 bits wide.

`default_nettype none

`include "pathOram_params.svh"

package hostRegPkg;

	// ==============================
	// register offsets
	// ==============================
	localparam logic [7:0] REQ_ADDR = 8'h00;
	localparam logic [7:0] STATUS_ADDR = 8'h04;

	// request word
	localparam int reqLeafLsb = 0;
	localparam int reqLeafMsb = `ORAM_L - 1;
	localparam int reqReadBit = 16;
	localparam int reqHeaderBit = 17;

	// status word
	localparam int statusBusyBit = 0;
	localparam int statusCountLsb = 8;
	localparam int statusCountMsb = 15;

endpackage

`default_nettype wire

//--- hostApbRegs.sv
// APB slave for path requests, with no wait states.
// Only one path is in flight, and a request written while busy is dropped with PSLVERR.
// The completed count is 8 bits and wraps at 256.

`timescale 1ns/1ns
`default_nettype none

`include "pathOram_params.svh"

module hostApbRegs (
	input logic Clock,
	input logic rstN,
	input logic PSEL,
	input logic PENABLE,
	input logic PWRITE,
	input logic [7:0] PADDR,
	input logic [31:0] PWDATA,
	output logic [31:0] PRDATA,
	output logic PREADY,
	output logic PSLVERR,
	output logic start,
	output logic [`ORAM_L-1:0] leaf,
	output logic readReq,
	output logic headerReq,
	input logic pathDone
);

	logic reqWrite;
	logic accept;
	logic busy;
	logic [7:0] doneCount;
	logic [31:0] statusWord;

	// access phase write to the request register
	assign reqWrite = PSEL && PENABLE && PWRITE && (PADDR == hostRegPkg::REQ_ADDR);
	assign accept = reqWrite && !busy;

	assign PREADY = 1'b1;
	assign PSLVERR = reqWrite && busy;

	always_comb begin
		statusWord = '0;
		statusWord[hostRegPkg::statusBusyBit] = busy;
		statusWord[hostRegPkg::statusCountMsb:hostRegPkg::statusCountLsb] = doneCount;
	end

	// only the status register reads back
	assign PRDATA = (PADDR == hostRegPkg::STATUS_ADDR) ? statusWord : '0;

	// ==============================
	// control state
	// ==============================
	always_ff @(posedge Clock or negedge rstN) begin
		if (!rstN) begin
			start <= 1'b0;
			busy <= 1'b0;
			doneCount <= '0;
		end else begin
			start <= accept;
			if (accept) begin
				busy <= 1'b1;
			end else if (pathDone) begin
				busy <= 1'b0;
			end
			if (pathDone) begin
				doneCount <= doneCount + 8'd1;
			end
		end
	end

	// request fields, held until the next accepted write
	always_ff @(posedge Clock) begin
		if (accept) begin
			leaf <= PWDATA[hostRegPkg::reqLeafMsb:hostRegPkg::reqLeafLsb];
			readReq <= PWDATA[hostRegPkg::reqReadBit];
			headerReq <= PWDATA[hostRegPkg::reqHeaderBit];
		end
	end

endmodule

`default_nettype wire

//--- pathAddrGen.sv
// Walks one path from the root bucket to the leaf bucket, one push per burst.
// A start pulse while a walk is running restarts the walk, so the host side must hold off.
// Leaf bits are used from the most significant bit down.

`timescale 1ns/1ns
`default_nettype none

`include "pathOram_params.svh"

module pathAddrGen (
	input logic Clock,
	input logic rstN,
	input logic start,
	input logic [`ORAM_L-1:0] leaf,
	input logic readReq,
	input logic headerReq,
	input logic full,
	output logic push,
	output dramCmdPkg::dramCmdE cmd,
	output dramCmdPkg::dramAddrU addr,
	output logic last
);

	localparam int levelW = $clog2(`ORAM_L + 1);
	localparam int burstW = dramCmdPkg::burstW;
	localparam int bucketW = dramCmdPkg::bucketW;

	logic active;
	logic [levelW-1:0] level;
	logic [bucketW-1:0] bucketIdx;
	logic [bucketW-1:0] childIdx;
	logic [burstW-1:0] burst;
	logic [`ORAM_L-1:0] leafSr;
	logic readMode;
	logic headerMode;
	logic lastBurst;
	logic lastLevel;

	assign lastBurst = headerMode ? (burst == burstW'(`HDR_BURSTS - 1))
		: (burst == burstW'(`BKT_BURSTS - 1));
	assign lastLevel = (level == levelW'(`ORAM_L));

	// child is 2*idx + 1 + next leaf bit
	assign childIdx = {bucketIdx[bucketW-2:0], 1'b1} + {{(bucketW-1){1'b0}}, leafSr[`ORAM_L-1]};

	assign push = active && !full;
	assign last = lastBurst && lastLevel;
	assign cmd = readMode ? dramCmdPkg::cmdRead : dramCmdPkg::cmdWrite;

	always_comb begin
		addr.fields.bucket = bucketIdx;
		addr.fields.burst = burst;
		addr.fields.offset = '0;
	end

	// ==============================
	// path walk
	// ==============================
	always_ff @(posedge Clock or negedge rstN) begin
		if (!rstN) begin
			active <= 1'b0;
			level <= '0;
			bucketIdx <= '0;
			burst <= '0;
		end else if (start) begin
			active <= 1'b1;
			level <= '0;
			bucketIdx <= '0;
			burst <= '0;
		end else if (push) begin
			if (!lastBurst) begin
				burst <= burst + 1'b1;
			end else begin
				burst <= '0;
				if (lastLevel) begin
					active <= 1'b0;
				end else begin
					level <= level + 1'b1;
					bucketIdx <= childIdx;
				end
			end
		end
	end

	// request copy, leaf shifts left at each level step
	always_ff @(posedge Clock) begin
		if (start) begin
			leafSr <= leaf;
			readMode <= readReq;
			headerMode <= headerReq;
		end else if (push && lastBurst && !lastLevel) begin
			leafSr <= leafSr << 1;
		end
	end

endmodule

`default_nettype wire

//--- cmdFifo.sv
// Synchronous FIFO of DRAM command entries, first word visible at the head.
// Push while full and pop while empty are ignored.

`timescale 1ns/1ns
`default_nettype none

module cmdFifo #(
	parameter int DEPTH = 4
) (
	input logic Clock,
	input logic rstN,
	input logic push,
	input dramCmdPkg::dramCmdE inCmd,
	input dramCmdPkg::dramAddrU inAddr,
	input logic inLast,
	input logic pop,
	output dramCmdPkg::dramCmdE outCmd,
	output dramCmdPkg::dramAddrU outAddr,
	output logic outLast,
	output logic notEmpty,
	output logic full
);

	localparam int ptrW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int cntW = $clog2(DEPTH + 1);

	dramCmdPkg::dramCmdE cmdMem [DEPTH];
	dramCmdPkg::dramAddrU addrMem [DEPTH];
	logic lastMem [DEPTH];
	logic [ptrW-1:0] wrPtr;
	logic [ptrW-1:0] rdPtr;
	logic [cntW-1:0] count;
	logic doPush;
	logic doPop;

	assign full = (count == cntW'(DEPTH));
	assign notEmpty = (count != '0);
	assign doPush = push && !full;
	assign doPop = pop && notEmpty;

	assign outCmd = cmdMem[rdPtr];
	assign outAddr = addrMem[rdPtr];
	assign outLast = lastMem[rdPtr];

	// pointers wrap explicitly
	always_ff @(posedge Clock or negedge rstN) begin
		if (!rstN) begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end else begin
			if (doPush) begin
				wrPtr <= (wrPtr == ptrW'(DEPTH - 1)) ? '0 : wrPtr + 1'b1;
			end
			if (doPop) begin
				rdPtr <= (rdPtr == ptrW'(DEPTH - 1)) ? '0 : rdPtr + 1'b1;
			end
			if (doPush && !doPop) begin
				count <= count + 1'b1;
			end else if (doPop && !doPush) begin
				count <= count - 1'b1;
			end
		end
	end

	always_ff @(posedge Clock) begin
		if (doPush) begin
			cmdMem[wrPtr] <= inCmd;
			addrMem[wrPtr] <= inAddr;
			lastMem[wrPtr] <= inLast;
		end
	end

endmodule

`default_nettype wire

//--- dramCmdIssue.sv
// Output register stage toward the DRAM command port.
// Cmd and Addr hold while CmdValid is high and CmdReady is low.
// pathDone comes one cycle after the last burst of a path is accepted.

`timescale 1ns/1ns
`default_nettype none

`include "pathOram_params.svh"

module dramCmdIssue (
	input logic Clock,
	input logic rstN,
	input logic notEmpty,
	input dramCmdPkg::dramCmdE headCmd,
	input dramCmdPkg::dramAddrU headAddr,
	input logic headLast,
	output logic pop,
	output logic CmdValid,
	output dramCmdPkg::dramCmdE Cmd,
	output logic [`DDR_AW-1:0] Addr,
	input logic CmdReady,
	output logic pathDone
);

	logic regLast;
	logic regFree;

	// register empty, or its entry leaves this cycle
	assign regFree = !CmdValid || CmdReady;
	assign pop = notEmpty && regFree;

	always_ff @(posedge Clock or negedge rstN) begin
		if (!rstN) begin
			CmdValid <= 1'b0;
			pathDone <= 1'b0;
		end else begin
			if (regFree) begin
				CmdValid <= notEmpty;
			end
			pathDone <= CmdValid && CmdReady && regLast;
		end
	end

	// payload
	always_ff @(posedge Clock) begin
		if (pop) begin
			Cmd <= headCmd;
			Addr <= headAddr.raw;
			regLast <= headLast;
		end
	end

endmodule

`default_nettype wire

//--- pathOramTop.sv
// Path ORAM address front end, APB host side and valid/ready DRAM command side.
// Holds one path at a time, buckets in heap order, no encryption or stash.

`timescale 1ns/1ns
`default_nettype none

`include "pathOram_params.svh"

module pathOramTop (
	input logic Clock,
	input logic rstN,
	input logic PSEL,
	input logic PENABLE,
	input logic PWRITE,
	input logic [7:0] PADDR,
	input logic [31:0] PWDATA,
	output logic [31:0] PRDATA,
	output logic PREADY,
	output logic PSLVERR,
	output logic CmdValid,
	output dramCmdPkg::dramCmdE Cmd,
	output logic [`DDR_AW-1:0] Addr,
	input logic CmdReady
);

	logic start;
	logic [`ORAM_L-1:0] leaf;
	logic readReq;
	logic headerReq;
	logic pathDone;
	// generator to FIFO
	logic genPush;
	dramCmdPkg::dramCmdE genCmd;
	dramCmdPkg::dramAddrU genAddr;
	logic genLast;
	logic fifoFull;
	// FIFO to issue stage
	dramCmdPkg::dramCmdE headCmd;
	dramCmdPkg::dramAddrU headAddr;
	logic headLast;
	logic notEmpty;
	logic pop;

	hostApbRegs hostApbRegs_inst (
		.Clock(Clock), .rstN(rstN),
		.PSEL(PSEL), .PENABLE(PENABLE), .PWRITE(PWRITE),
		.PADDR(PADDR), .PWDATA(PWDATA), .PRDATA(PRDATA),
		.PREADY(PREADY), .PSLVERR(PSLVERR),
		.start(start), .leaf(leaf), .readReq(readReq), .headerReq(headerReq),
		.pathDone(pathDone)
	);

	pathAddrGen pathAddrGen_inst (
		.Clock(Clock), .rstN(rstN),
		.start(start), .leaf(leaf), .readReq(readReq), .headerReq(headerReq),
		.full(fifoFull),
		.push(genPush), .cmd(genCmd), .addr(genAddr), .last(genLast)
	);

	cmdFifo #(.DEPTH(`CMD_FIFO_DEPTH)) cmdFifo_inst (
		.Clock(Clock), .rstN(rstN),
		.push(genPush), .inCmd(genCmd), .inAddr(genAddr), .inLast(genLast),
		.pop(pop),
		.outCmd(headCmd), .outAddr(headAddr), .outLast(headLast),
		.notEmpty(notEmpty), .full(fifoFull)
	);

	dramCmdIssue dramCmdIssue_inst (
		.Clock(Clock), .rstN(rstN),
		.notEmpty(notEmpty), .headCmd(headCmd), .headAddr(headAddr), .headLast(headLast),
		.pop(pop),
		.CmdValid(CmdValid), .Cmd(Cmd), .Addr(Addr), .CmdReady(CmdReady),
		.pathDone(pathDone)
	);

endmodule

`default_nettype wire

//--- tbClockGen.sv
// Clock and reset source for the testbench.
// 20 ns period, rstN held low for the first 5 rising edges.

`timescale 1ns/1ns
`default_nettype none

module tbClockGen (
	output logic Clock,
	output logic rstN
);

	initial begin
		Clock = 1'b0;
		forever #10 Clock = ~Clock;
	end

	// release on a falling edge, away from the DUT edge
	initial begin
		rstN = 1'b0;
		repeat (5) @(posedge Clock);
		@(negedge Clock);
		rstN = 1'b1;
	end

endmodule

`default_nettype wire

//--- pathOramTb.sv
// Testbench for the path ORAM address front end.
// Applies a table of path requests over APB and checks every accepted DRAM command.
// CmdReady is random from $urandom with a fixed seed, and inputs change on falling edges.

`timescale 1ns/1ns
`default_nettype none

`include "pathOram_params.svh"

module pathOramTb;

	localparam int numReq = 6;
	localparam int collectLimit = 2000;
	localparam int pollLimit = 50;

	logic Clock;
	logic rstN;
	logic PSEL;
	logic PENABLE;
	logic PWRITE;
	logic [7:0] PADDR;
	logic [31:0] PWDATA;
	logic [31:0] PRDATA;
	logic PREADY;
	logic PSLVERR;
	logic CmdValid;
	dramCmdPkg::dramCmdE Cmd;
	logic [`DDR_AW-1:0] Addr;
	logic CmdReady;

	// request table: leaf, read flag, header flag
	int leafTab [numReq] = '{0, 15, 5, 10, 9, 6};
	bit readTab [numReq] = '{0, 1, 1, 0, 1, 0};
	bit headerTab [numReq] = '{0, 0, 1, 1, 0, 0};

	logic [31:0] expAddr [$];

	tbClockGen clockGen_inst (.Clock(Clock), .rstN(rstN));

	pathOramTop pathOramTop_inst (
		.Clock(Clock), .rstN(rstN),
		.PSEL(PSEL), .PENABLE(PENABLE), .PWRITE(PWRITE),
		.PADDR(PADDR), .PWDATA(PWDATA), .PRDATA(PRDATA),
		.PREADY(PREADY), .PSLVERR(PSLVERR),
		.CmdValid(CmdValid), .Cmd(Cmd), .Addr(Addr), .CmdReady(CmdReady)
	);

	// ==============================
	// checks
	// ==============================
	task automatic checkEq(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		if (actual !== expected) begin
			$display("Fail at %0t ns: %s is %h, expected %h", $time, name, actual, expected);
			$display("Simulation finished: FAIL");
			$fatal(1, "value mismatch");
		end
	endtask

	task automatic abortRun(input string reason);
		$display("Error at %0t ns: %s", $time, reason);
		$display("Simulation finished: FAIL");
		$fatal(1, "run aborted");
	endtask

	// ==============================
	// APB host side
	// ==============================
	task automatic apbWrite(input logic [7:0] a, input logic [31:0] d, output logic err);
		@(negedge Clock);
		PSEL = 1'b1;
		PENABLE = 1'b0;
		PWRITE = 1'b1;
		PADDR = a;
		PWDATA = d;
		@(negedge Clock);
		PENABLE = 1'b1;
		#5;
		checkEq("PREADY", PREADY, 1);
		err = PSLVERR;
		@(negedge Clock);
		PSEL = 1'b0;
		PENABLE = 1'b0;
		PWRITE = 1'b0;
	endtask

	task automatic apbRead(input logic [7:0] a, output logic [31:0] d);
		@(negedge Clock);
		PSEL = 1'b1;
		PENABLE = 1'b0;
		PWRITE = 1'b0;
		PADDR = a;
		@(negedge Clock);
		PENABLE = 1'b1;
		#5;
		checkEq("PREADY", PREADY, 1);
		d = PRDATA;
		@(negedge Clock);
		PSEL = 1'b0;
		PENABLE = 1'b0;
	endtask

	// heap order walk, root to leaf, MSB of the leaf first
	task automatic buildExpected(input int leafVal, input bit hdr);
		int bucket;
		int bursts;
		expAddr.delete();
		bucket = 0;
		bursts = hdr ? `HDR_BURSTS : `BKT_BURSTS;
		for (int lvl = 0; lvl <= `ORAM_L; lvl++) begin
			for (int b = 0; b < bursts; b++) begin
				expAddr.push_back(32'((bucket * `BKT_BURSTS + b) << `BST_BYTES_LOG));
			end
			if (lvl < `ORAM_L) begin
				bucket = 2 * bucket + 1 + ((leafVal >> (`ORAM_L - 1 - lvl)) & 1);
			end
		end
	endtask

	function automatic logic [31:0] reqWord(input int leafVal, input bit rd, input bit hdr);
		logic [31:0] w;
		w = '0;
		w[hostRegPkg::reqLeafMsb:hostRegPkg::reqLeafLsb] = leafVal[`ORAM_L-1:0];
		w[hostRegPkg::reqReadBit] = rd;
		w[hostRegPkg::reqHeaderBit] = hdr;
		return w;
	endfunction

	initial begin
		logic err;
		logic [31:0] status;
		int got;
		int cycles;
		void'($urandom(32'ha8f8));
		PSEL = 1'b0;
		PENABLE = 1'b0;
		PWRITE = 1'b0;
		PADDR = '0;
		PWDATA = '0;
		CmdReady = 1'b0;

		cycles = 0;
		while (rstN !== 1'b1) begin
			@(negedge Clock);
			cycles++;
			if (cycles > pollLimit) abortRun("reset never released");
		end
		checkEq("CmdValid", CmdValid, 0);
		checkEq("PSLVERR", PSLVERR, 0);
		apbRead(hostRegPkg::STATUS_ADDR, status);
		checkEq("STATUS", status, 0);

		for (int i = 0; i < numReq; i++) begin
			buildExpected(leafTab[i], headerTab[i]);
			CmdReady = 1'b0;
			apbWrite(hostRegPkg::REQ_ADDR, reqWord(leafTab[i], readTab[i], headerTab[i]), err);
			checkEq("PSLVERR", err, 0);
			// second request while busy must be refused
			apbWrite(hostRegPkg::REQ_ADDR, reqWord(leafTab[i] ^ 3, !readTab[i], 0), err);
			checkEq("PSLVERR", err, 1);

			got = 0;
			cycles = 0;
			while (got < expAddr.size()) begin
				@(negedge Clock);
				CmdReady = ($urandom_range(3) != 0);
				#1;
				if (CmdValid && CmdReady) begin
					checkEq("Addr", Addr, expAddr[got]);
					checkEq("Cmd", 32'(Cmd), 32'(readTab[i]));
					got++;
				end
				cycles++;
				if (cycles > collectLimit) abortRun("DRAM commands stopped before end of path");
			end

			@(negedge Clock);
			CmdReady = 1'b1;
			cycles = 0;
			status = 32'h1;
			while (status[hostRegPkg::statusBusyBit]) begin
				apbRead(hostRegPkg::STATUS_ADDR, status);
				checkEq("CmdValid", CmdValid, 0);
				cycles++;
				if (cycles > pollLimit) abortRun("busy never cleared after path");
			end
			checkEq("STATUS.count",
				status[hostRegPkg::statusCountMsb:hostRegPkg::statusCountLsb], i + 1);
		end

		$display("Simulation finished: PASS");
		$finish;
	end

endmodule

`default_nettype wire

//--- project.f
+incdir+.
dramCmdPkg.sv
hostRegPkg.sv
hostApbRegs.sv
pathAddrGen.sv
cmdFifo.sv
dramCmdIssue.sv
pathOramTop.sv
tbClockGen.sv
pathOramTb.sv

//--- runSim.sh
#!/bin/bash
# Build with Verilator and run the path ORAM testbench from the project root.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module pathOramTb -f project.f \
	-Mdir obj_dir -o pathOramSim > build.log 2>&1 \
	|| { echo "build failed, see build.log"; exit 1; }

./obj_dir/pathOramSim > sim.log 2>&1
cat sim.log

grep -q "Simulation finished: FAIL" sim.log && exit 1
grep -q "Simulation finished: PASS" sim.log && exit 0 || exit 1
